// ==== build.f ====
design/store_pkg.sv
design/capture_fifo.sv
design/region_addr_gen.sv
design/burst_scheduler.sv
design/data_store_top.sv
verification/data_store_tb.sv

// ==== design/burst_scheduler.sv ====
`timescale 1ns/10ps

module burst_scheduler
  import store_pkg::*;
(
  input  logic        ddr3_user_clk,
  input  logic        fifo_rst_trig_corss_domian,
  input  fifo_count_t fifo_count [num_channels],
  input  data_t       fifo_head [num_channels],
  input  chan_mask_t  exhausted,
  input  addr_t       chan_addr [num_channels],
  output chan_mask_t  pop,
  output chan_mask_t  burst_done,
  output logic        wr_valid,
  input  logic        wr_ready,
  output addr_t       wr_addr,
  output data_t       wr_data,
  input  logic        wr_data_req,
  input  logic        wr_data_end
);

  logic [state_w-1:0] state;
  chan_mask_t         grant;
  chan_mask_t         eligible;
  chan_mask_t         pick;
  logic               in_data;

  ////////////////////////////////////////
  // eligibility and priority
  ////////////////////////////////////////

  // full burst buffered and region still open
  always_comb
  begin
    for (int c = 0; c < num_channels; c++)
    begin
      eligible[c] = (fifo_count[c] >= fifo_count_t'(burst_len)) && !exhausted[c];
    end
  end

  // lowest set bit wins, channel 0 first
  assign pick = eligible & (~eligible + chan_mask_t'(1));

  ////////////////////////////////////////
  // grant FSM
  ////////////////////////////////////////

  always_ff @(posedge ddr3_user_clk)
  begin
    if (fifo_rst_trig_corss_domian)
    begin
      state <= st_idle;
      grant <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (|eligible)
          begin
            grant <= pick;
            state <= st_cmd;
          end
        end
        st_cmd:
        begin
          // command held until the controller takes it
          if (wr_ready)
            state <= st_data;
        end
        st_data:
        begin
          if (wr_data_end)
          begin
            grant <= '0;
            state <= st_idle;
          end
        end
        default:
        begin
          grant <= '0;
          state <= st_idle;
        end
      endcase
    end
  end

  assign wr_valid = (state == st_cmd);
  assign in_data  = (state == st_data);

  ////////////////////////////////////////
  // data phase routing
  ////////////////////////////////////////

  // each request consumes the head word of the granted buffer
  assign pop        = in_data ? (grant & {num_channels{wr_data_req}}) : '0;
  assign burst_done = (in_data && wr_data_end) ? grant : '0;

  // address and data of the granted channel
  always_comb
  begin
    wr_addr = '0;
    wr_data = '0;
    for (int c = 0; c < num_channels; c++)
    begin
      if (grant[c])
      begin
        wr_addr = chan_addr[c];
        wr_data = fifo_head[c];
      end
    end
  end

endmodule

// ==== design/capture_fifo.sv ====
`timescale 1ns/10ps

module capture_fifo
  import store_pkg::*;
(
  input  logic        ddr3_user_clk,
  input  logic        fifo_rst_trig_corss_domian,
  input  data_t       in_data,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic        pop,
  output data_t       head,
  output fifo_count_t count
);

  data_t            mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic             push;

  // not full
  assign in_ready = (count != fifo_count_t'(fifo_depth));
  assign push     = in_valid && in_ready;

  // first word fall through
  assign head = mem[rd_ptr];

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge ddr3_user_clk)
  begin
    if (fifo_rst_trig_corss_domian)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // pointers wrap at the depth
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // sample storage
  always_ff @(posedge ddr3_user_clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

endmodule

// ==== design/data_store_top.sv ====
`timescale 1ns/10ps

module data_store_top
  import store_pkg::*;
(
  input  logic  ddr3_user_clk,
  input  logic  fifo_rst_trig_corss_domian,
  input  data_t sample_data_0,
  input  logic  sample_valid_0,
  output logic  sample_ready_0,
  input  data_t sample_data_1,
  input  logic  sample_valid_1,
  output logic  sample_ready_1,
  input  data_t sample_data_2,
  input  logic  sample_valid_2,
  output logic  sample_ready_2,
  output logic  wr_valid,
  input  logic  wr_ready,
  output addr_t wr_addr,
  output data_t wr_data,
  input  logic  wr_data_req,
  input  logic  wr_data_end
);

  // per channel status gathered for the scheduler
  fifo_count_t fifo_count [num_channels];
  data_t       fifo_head [num_channels];
  addr_t       chan_addr [num_channels];
  chan_mask_t  exhausted;
  chan_mask_t  pop;
  chan_mask_t  burst_done;

  ////////////////////////////////////////
  // channel buffers
  ////////////////////////////////////////

  capture_fifo u_fifo_0 (
    .ddr3_user_clk              (ddr3_user_clk),
    .fifo_rst_trig_corss_domian (fifo_rst_trig_corss_domian),
    .in_data                    (sample_data_0),
    .in_valid                   (sample_valid_0),
    .in_ready                   (sample_ready_0),
    .pop                        (pop[0]),
    .head                       (fifo_head[0]),
    .count                      (fifo_count[0])
  );

  capture_fifo u_fifo_1 (
    .ddr3_user_clk              (ddr3_user_clk),
    .fifo_rst_trig_corss_domian (fifo_rst_trig_corss_domian),
    .in_data                    (sample_data_1),
    .in_valid                   (sample_valid_1),
    .in_ready                   (sample_ready_1),
    .pop                        (pop[1]),
    .head                       (fifo_head[1]),
    .count                      (fifo_count[1])
  );

  capture_fifo u_fifo_2 (
    .ddr3_user_clk              (ddr3_user_clk),
    .fifo_rst_trig_corss_domian (fifo_rst_trig_corss_domian),
    .in_data                    (sample_data_2),
    .in_valid                   (sample_valid_2),
    .in_ready                   (sample_ready_2),
    .pop                        (pop[2]),
    .head                       (fifo_head[2]),
    .count                      (fifo_count[2])
  );

  ////////////////////////////////////////
  // addressing and arbitration
  ////////////////////////////////////////

  region_addr_gen u_addr_gen (
    .ddr3_user_clk              (ddr3_user_clk),
    .fifo_rst_trig_corss_domian (fifo_rst_trig_corss_domian),
    .burst_done                 (burst_done),
    .chan_addr                  (chan_addr),
    .exhausted                  (exhausted)
  );

  burst_scheduler u_sched (
    .ddr3_user_clk              (ddr3_user_clk),
    .fifo_rst_trig_corss_domian (fifo_rst_trig_corss_domian),
    .fifo_count                 (fifo_count),
    .fifo_head                  (fifo_head),
    .exhausted                  (exhausted),
    .chan_addr                  (chan_addr),
    .pop                        (pop),
    .burst_done                 (burst_done),
    .wr_valid                   (wr_valid),
    .wr_ready                   (wr_ready),
    .wr_addr                    (wr_addr),
    .wr_data                    (wr_data),
    .wr_data_req                (wr_data_req),
    .wr_data_end                (wr_data_end)
  );

endmodule

// ==== design/region_addr_gen.sv ====
`timescale 1ns/10ps

module region_addr_gen
  import store_pkg::*;
(
  input  logic       ddr3_user_clk,
  input  logic       fifo_rst_trig_corss_domian,
  input  chan_mask_t burst_done,
  output addr_t      chan_addr [num_channels],
  output chan_mask_t exhausted
);

  // completed bursts per channel
  logic [burst_cnt_w-1:0] burst_cnt [num_channels];

  ////////////////////////////////////////
  // region exhausted flags
  ////////////////////////////////////////

  // rises as soon as the last burst is counted
  always_comb
  begin
    for (int c = 0; c < num_channels; c++)
    begin
      exhausted[c] = (burst_cnt[c] == burst_cnt_w'(region_bursts));
    end
  end

  ////////////////////////////////////////
  // address and burst counters
  ////////////////////////////////////////

  always_ff @(posedge ddr3_user_clk)
  begin
    for (int c = 0; c < num_channels; c++)
    begin
      if (fifo_rst_trig_corss_domian)
      begin
        chan_addr[c] <= region_base[c];
        burst_cnt[c] <= '0;
      end
      else if (burst_done[c] && !exhausted[c])
      begin
        // step one burst inside the region
        chan_addr[c] <= chan_addr[c] + burst_addr_step;
        burst_cnt[c] <= burst_cnt[c] + 1'b1;
      end
    end
  end

  // once mode, the region holds its last address until reset

endmodule

// ==== design/store_pkg.sv ====
package store_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int num_channels = 3;
  localparam int data_w       = 128;
  localparam int addr_w       = 32;

  // fill count holds 0 to fifo_depth
  localparam int count_w      = 5;

  ////////////////////////////////////////
  // buffering and bursts
  ////////////////////////////////////////

  localparam int fifo_depth   = 16;
  localparam int ptr_w        = 4;

  // words per burst, also the request threshold
  localparam int burst_len    = 8;

  // bursts a region takes before it stops
  localparam int region_bursts = 4;
  localparam int burst_cnt_w   = 3;

  // scheduler states
  localparam int state_w = 2;
  localparam logic [state_w-1:0] st_idle = 2'd0;
  localparam logic [state_w-1:0] st_cmd  = 2'd1;
  localparam logic [state_w-1:0] st_data = 2'd2;

  ////////////////////////////////////////
  // shared types
  ////////////////////////////////////////

  typedef logic [data_w-1:0]       data_t;
  typedef logic [addr_w-1:0]       addr_t;
  typedef logic [num_channels-1:0] chan_mask_t;
  typedef logic [count_w-1:0]      fifo_count_t;

  // one burst of 8 x 128 bits in controller address units
  localparam addr_t burst_addr_step = 32'd128;

  localparam addr_t region_base [num_channels] = '{
    32'h8000_0000,
    32'h9900_0000,
    32'hB200_0000
  };

endpackage

// ==== verification/data_store_tb.sv ====
`timescale 1ns/10ps

module data_store_tb
  import store_pkg::*;
();

  localparam int ready_timeout = 200;
  localparam int burst_timeout = 1000;

  logic                    ddr3_user_clk;
  logic                    fifo_rst_trig_corss_domian;
  data_t                   sample_data [num_channels];
  logic [num_channels-1:0] sample_valid;
  wire  [num_channels-1:0] sample_ready;
  logic                    wr_valid;
  logic                    wr_ready;
  addr_t                   wr_addr;
  data_t                   wr_data;
  logic                    wr_data_req;
  logic                    wr_data_end;

  integer seed = 32'h4f74;

  // stream position per channel and bursts seen by the checker
  int     next_idx [num_channels];
  int     bursts_seen [num_channels];
  int     active_chan;
  int     beat_idx;
  int     first_chan_expect;
  logic   hold_pending;
  addr_t  held_addr;

  data_store_top dut_i (
    .ddr3_user_clk              (ddr3_user_clk),
    .fifo_rst_trig_corss_domian (fifo_rst_trig_corss_domian),
    .sample_data_0              (sample_data[0]),
    .sample_valid_0             (sample_valid[0]),
    .sample_ready_0             (sample_ready[0]),
    .sample_data_1              (sample_data[1]),
    .sample_valid_1             (sample_valid[1]),
    .sample_ready_1             (sample_ready[1]),
    .sample_data_2              (sample_data[2]),
    .sample_valid_2             (sample_valid[2]),
    .sample_ready_2             (sample_ready[2]),
    .wr_valid                   (wr_valid),
    .wr_ready                   (wr_ready),
    .wr_addr                    (wr_addr),
    .wr_data                    (wr_data),
    .wr_data_req                (wr_data_req),
    .wr_data_end                (wr_data_end)
  );

  initial
  begin
    ddr3_user_clk = 1'b0;
    forever #5 ddr3_user_clk = ~ddr3_user_clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // channel number in the top byte and stream index below
  function automatic data_t stream_word(input int chan, input int idx);
    return data_t'(idx) | (data_t'(chan) << (data_w - 8));
  endfunction

  function automatic addr_t expected_addr(input int chan, input int burst);
    return region_base[chan] + addr_t'(burst) * burst_addr_step;
  endfunction

  function automatic data_t expected_word(input int chan, input int burst, input int beat);
    return stream_word(chan, burst * burst_len + beat);
  endfunction

  function automatic int chan_from_addr(input addr_t addr);
    int found;
    found = -1;
    for (int c = 0; c < num_channels; c++)
    begin
      if (addr >= region_base[c] && addr < region_base[c] + region_bursts * burst_addr_step)
        found = c;
    end
    return found;
  endfunction

  ////////////////////////////////////////
  // error handling and compares
  ////////////////////////////////////////

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic compare_addr(input string name, input addr_t actual, input addr_t expected);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic compare_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic compare_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // controller model
  ////////////////////////////////////////

  initial
  begin : controller_model
    int delay;
    int beat;
    wr_ready    = 1'b0;
    wr_data_req = 1'b0;
    wr_data_end = 1'b0;
    forever
    begin
      @(posedge ddr3_user_clk);
      #1;
      if (!fifo_rst_trig_corss_domian && wr_valid === 1'b1)
      begin
        // stall the command for 0 to 3 cycles
        delay = $random(seed) & 3;
        repeat (delay)
        begin
          @(posedge ddr3_user_clk);
          #1;
        end
        wr_ready = 1'b1;
        @(posedge ddr3_user_clk);
        #1;
        wr_ready = 1'b0;
        beat = 0;
        while (beat < burst_len)
        begin
          if (($random(seed) & 3) == 0)
          begin
            @(posedge ddr3_user_clk);
            #1;
          end
          wr_data_req = 1'b1;
          wr_data_end = (beat == burst_len - 1);
          @(posedge ddr3_user_clk);
          #1;
          wr_data_req = 1'b0;
          wr_data_end = 1'b0;
          beat++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // bus checker
  ////////////////////////////////////////

  task automatic check_command();
    int ch;
    begin
      if (first_chan_expect >= 0)
      begin
        ch = first_chan_expect;
        first_chan_expect = -1;
      end
      else
        ch = chan_from_addr(wr_addr);
      if (ch < 0)
        report_error($sformatf("command address %h lies in no channel region", wr_addr));
      if (bursts_seen[ch] >= region_bursts)
        report_error($sformatf("command issued for exhausted channel %0d", ch));
      compare_addr("wr_addr", wr_addr, expected_addr(ch, bursts_seen[ch]));
      active_chan = ch;
      beat_idx = 0;
    end
  endtask

  task automatic check_beat();
    compare_data("wr_data", wr_data,
                 expected_word(active_chan, bursts_seen[active_chan], beat_idx));
    if (wr_data_end)
    begin
      bursts_seen[active_chan]++;
      active_chan = -1;
    end
    else
      beat_idx++;
  endtask

  // sampled mid cycle where all outputs are settled
  initial
  begin : bus_checker
    active_chan  = -1;
    beat_idx     = 0;
    hold_pending = 1'b0;
    held_addr    = '0;
    forever
    begin
      @(negedge ddr3_user_clk);
      if (fifo_rst_trig_corss_domian)
      begin
        active_chan  = -1;
        hold_pending = 1'b0;
      end
      else
      begin
        // only one burst granted at a time
        if (active_chan >= 0 && wr_valid === 1'b1)
          report_error("wr_valid raised during a data burst");
        // a stalled command stays valid and stable
        if (hold_pending)
        begin
          compare_flag("wr_valid", wr_valid, 1'b1);
          compare_addr("wr_addr", wr_addr, held_addr);
        end
        hold_pending = (wr_valid === 1'b1) && (wr_ready === 1'b0);
        held_addr    = wr_addr;
        if (wr_valid === 1'b1 && wr_ready === 1'b1)
          check_command();
        if (wr_data_req === 1'b1)
          check_beat();
      end
    end
  end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  task automatic apply_reset();
    fifo_rst_trig_corss_domian = 1'b1;
    sample_valid = '0;
    repeat (2) @(posedge ddr3_user_clk);
    #1;
    fifo_rst_trig_corss_domian = 1'b0;
    for (int c = 0; c < num_channels; c++)
    begin
      next_idx[c]    = 0;
      bursts_seen[c] = 0;
    end
    first_chan_expect = -1;
  endtask

  task automatic send_words(input int chan, input int n, input bit gaps);
    int sent;
    int cycles;
    begin
      sent = 0;
      while (sent < n)
      begin
        if (gaps && (($random(seed) & 3) == 0))
        begin
          sample_valid[chan] = 1'b0;
          @(posedge ddr3_user_clk);
          #1;
        end
        sample_valid[chan] = 1'b1;
        sample_data[chan]  = stream_word(chan, next_idx[chan]);
        cycles = 0;
        @(negedge ddr3_user_clk);
        while (sample_ready[chan] !== 1'b1)
        begin
          cycles++;
          if (cycles > ready_timeout)
            report_error($sformatf("timed out waiting for sample_ready_%0d", chan));
          @(negedge ddr3_user_clk);
        end
        // taken on the next rising edge
        @(posedge ddr3_user_clk);
        #1;
        next_idx[chan]++;
        sent++;
      end
      sample_valid[chan] = 1'b0;
    end
  endtask

  task automatic wait_bursts(input int b0, input int b1, input int b2);
    int cycles;
    begin
      cycles = 0;
      while (bursts_seen[0] != b0 || bursts_seen[1] != b1 || bursts_seen[2] != b2)
      begin
        cycles++;
        if (cycles > burst_timeout)
          report_error($sformatf("timed out waiting for bursts %0d %0d %0d", b0, b1, b2));
        @(posedge ddr3_user_clk);
        #1;
      end
    end
  endtask

  task automatic check_idle_outputs();
    compare_flag("wr_valid", wr_valid, 1'b0);
    for (int c = 0; c < num_channels; c++)
      compare_flag($sformatf("sample_ready_%0d", c), sample_ready[c], 1'b1);
  endtask

  // channel 0 full and exhausted while the bus stays quiet
  task automatic watch_exhausted(input int n);
    repeat (n)
    begin
      @(negedge ddr3_user_clk);
      compare_flag("sample_ready_0", sample_ready[0], 1'b0);
      compare_flag("wr_valid", wr_valid, 1'b0);
    end
    @(posedge ddr3_user_clk);
    #1;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial
  begin : main_sequence
    for (int c = 0; c < num_channels; c++)
      sample_data[c] = '0;
    sample_valid = '0;
    fifo_rst_trig_corss_domian = 1'b1;
    apply_reset();
    check_idle_outputs();

    // two bursts from one channel alone
    send_words(0, 2 * burst_len, 1'b1);
    wait_bursts(2, 0, 0);

    // all channels full in the same cycle
    first_chan_expect = 0;
    fork
      send_words(0, burst_len, 1'b0);
      send_words(1, burst_len, 1'b0);
      send_words(2, burst_len, 1'b0);
    join
    wait_bursts(3, 1, 1);
    fork
      send_words(0, burst_len, 1'b1);
      send_words(1, burst_len, 1'b1);
      send_words(2, burst_len, 1'b1);
    join
    wait_bursts(4, 2, 2);

    // region 0 used up
    send_words(0, fifo_depth, 1'b1);
    watch_exhausted(20);

    // reset with partial bursts buffered
    fork
      send_words(1, 5, 1'b1);
      send_words(2, 3, 1'b1);
    join
    apply_reset();
    check_idle_outputs();
    fork
      send_words(0, 2 * burst_len, 1'b1);
      send_words(1, 2 * burst_len, 1'b1);
      send_words(2, 2 * burst_len, 1'b1);
    join
    wait_bursts(2, 2, 2);

    $display("all tests passed");
    $finish;
  end

endmodule
